/* board_pkg.sv */
package board_pkg;

    // Bus widths
    localparam int joy_w       = 16;   // Board joystick word
    localparam int game_joy_w  = 10;   // Game side joystick
    localparam int status_w    = 32;   // OSD status word
    localparam int out_color_w = 8;    // Colour per channel at the output
    localparam int gfx_w       = 4;    // Graphics layers with an enable

    // Joystick word map, before the three-button offset
    localparam int start1_base = 6;
    localparam int start2_base = 7;
    localparam int coin_base   = 8;
    localparam int pause_base  = 9;

    // OSD status word map
    localparam int st_rotate = 2;
    localparam int st_test   = 10;
    localparam int st_pause  = 11;
    localparam int st_flip   = 12;
    localparam int st_fx_lo  = 13;    // Two bits wide

endpackage

/* board_ctrl.sv */
module board_ctrl #(
    parameter int rst_cnt_w = 8
) (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        downloading,
    input  logic                        rst_req,
    input  logic                        dip_flip,
    input  logic                        key_reset,
    input  logic                        key_pause,
    input  logic                        joy_pause,
    input  logic [board_pkg::gfx_w-1:0] key_gfx,
    output logic                        board_rst,
    output logic                        board_rst_n,
    output logic                        game_rst,
    output logic                        game_rst_n,
    output logic                        game_pause,
    output logic [board_pkg::gfx_w-1:0] gfx_en
);

    // Two reset lanes share the same counter logic
    // Lane 0 is the board reset, lane 1 the game reset
    logic [1:0]           rst_trig;
    logic [1:0]           rst_q;
    logic [1:0]           pre_rst_n;
    logic [1:0]           rst_n_q;
    logic [rst_cnt_w-1:0] rst_cnt [2];

    logic                        last_flip;
    logic                        last_reset;
    logic                        last_pause;
    logic                        last_joy_pause;
    logic [board_pkg::gfx_w-1:0] last_gfx;
    logic                        soft_rst;
    logic                        flip_chg;

    assign flip_chg    = last_flip != dip_flip;   // Any flip change restarts the game
    assign rst_trig[0] = rst;
    assign rst_trig[1] = rst | rst_q[0] | downloading | rst_req | flip_chg | soft_rst;

    // Hold counters, restarted by their trigger
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 2; i++) begin
            if (rst_trig[i]) begin
                rst_cnt[i] <= '0;
                rst_q[i]   <= 1'b1;
            end else if (rst_cnt[i] != '1) begin
                rst_cnt[i] <= rst_cnt[i] + 1'b1;
                rst_q[i]   <= 1'b1;
            end else begin
                rst_q[i] <= 1'b0;
            end
        end
    end

    // Active-low copies, released two cycles after the reset ends
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 2; i++) begin
            if (rst_trig[i] || rst_q[i]) begin
                pre_rst_n[i] <= 1'b0;
                rst_n_q[i]   <= 1'b0;
            end else begin
                pre_rst_n[i] <= 1'b1;
                rst_n_q[i]   <= pre_rst_n[i];
            end
        end
    end

    assign board_rst   = rst_q[0];
    assign game_rst    = rst_q[1];
    assign board_rst_n = rst_n_q[0];
    assign game_rst_n  = rst_n_q[1];

    always_ff @(posedge clk_sys) begin
        last_flip      <= dip_flip;
        last_reset     <= key_reset;
        last_pause     <= key_pause;
        last_joy_pause <= joy_pause;
        last_gfx       <= key_gfx;
        if (board_rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;        // All layers on
            soft_rst   <= 1'b0;
        end else begin
            soft_rst <= key_reset & ~last_reset;
            if ((key_pause && !last_pause) || (joy_pause && !last_joy_pause))
                game_pause <= ~game_pause;
            gfx_en <= gfx_en ^ (key_gfx & ~last_gfx);   // Flip only on rising keys
        end
    end

endmodule

/* input_mapper.sv */
module input_mapper #(
    parameter int three_buttons = 0,
    parameter bit active_low    = 1'b1
) (
    input  logic                             clk_sys,
    input  logic                             board_rst,
    input  logic [board_pkg::joy_w-1:0]      board_joystick1,
    input  logic [board_pkg::joy_w-1:0]      board_joystick2,
    input  logic [board_pkg::game_joy_w-1:0] key_joy1,
    input  logic [board_pkg::game_joy_w-1:0] key_joy2,
    input  logic [1:0]                       key_start,
    input  logic [1:0]                       key_coin,
    input  logic                             key_service,
    input  logic                             rot_control,
    output logic [board_pkg::game_joy_w-1:0] game_joystick1,
    output logic [board_pkg::game_joy_w-1:0] game_joystick2,
    output logic [1:0]                       game_coin,
    output logic [1:0]                       game_start,
    output logic                             game_service,
    output logic                             joy_pause
);

    localparam int gjw        = board_pkg::game_joy_w;
    localparam int start1_bit = board_pkg::start1_base + three_buttons;
    localparam int start2_bit = board_pkg::start2_base + three_buttons;
    localparam int coin_bit   = board_pkg::coin_base + three_buttons;
    localparam int pause_bit  = board_pkg::pause_base + three_buttons;

    logic [board_pkg::joy_w-1:0] joy1_sync;
    logic [board_pkg::joy_w-1:0] joy2_sync;
    logic [gjw-1:0]              key_joy1_sync;
    logic [gjw-1:0]              key_joy2_sync;
    logic [1:0]                  key_start_sync;
    logic [1:0]                  key_coin_sync;
    logic                        key_service_sync;

    // Direction swap for rotated screens, buttons untouched
    function automatic logic [gjw-1:0] rotate_dirs(input logic [gjw-1:0] joy,
                                                   input logic rot);
        logic [gjw-1:0] res;
        res = joy;
        if (rot)
            res[3:0] = {joy[0], joy[1], joy[3], joy[2]};
        return res;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync        <= board_joystick1;
        joy2_sync        <= board_joystick2;
        key_joy1_sync    <= key_joy1;
        key_joy2_sync    <= key_joy2;
        key_start_sync   <= key_start;
        key_coin_sync    <= key_coin;
        key_service_sync <= key_service;
    end

    assign joy_pause = joy1_sync[pause_bit] | joy2_sync[pause_bit];

    always_ff @(posedge clk_sys) begin
        if (board_rst) begin
            game_joystick1 <= {gjw{active_low}};   // Inactive level
            game_joystick2 <= {gjw{active_low}};
            game_coin      <= {2{active_low}};
            game_start     <= {2{active_low}};
            game_service   <= active_low;
        end else begin
            game_joystick1 <= {gjw{active_low}} ^
                rotate_dirs(joy1_sync[gjw-1:0] | key_joy1_sync, rot_control);
            game_joystick2 <= {gjw{active_low}} ^
                rotate_dirs(joy2_sync[gjw-1:0] | key_joy2_sync, rot_control);
            game_coin      <= {2{active_low}} ^
                ({joy2_sync[coin_bit], joy1_sync[coin_bit]} | key_coin_sync);
            // Either stick can start either player
            game_start     <= {2{active_low}} ^
                ({joy1_sync[start2_bit], joy1_sync[start1_bit]} |
                 {joy2_sync[start2_bit], joy2_sync[start1_bit]} | key_start_sync);
            game_service   <= active_low ^ key_service_sync;
        end
    end

endmodule

/* dip_decode.sv */
module dip_decode (
    input  logic                           clk_sys,
    input  logic [board_pkg::status_w-1:0] status,
    input  logic                           game_pause,
    output logic                           rot_control,
    output logic                           dip_test,
    output logic                           dip_flip,
    output logic                           dip_pause,
    output logic [1:0]                     dip_fxlevel
);

    logic pause_req;

    // Either the pause key state or the OSD setting stops the game
    assign pause_req = game_pause | status[board_pkg::st_pause];

    always_ff @(posedge clk_sys) begin
        rot_control <= status[board_pkg::st_rotate];
        dip_test    <= status[board_pkg::st_test];
        dip_flip    <= status[board_pkg::st_flip];     // Change here resets the game
        dip_fxlevel <= status[board_pkg::st_fx_lo +: 2];
        dip_pause   <= ~pause_req;                     // Active low
    end

endmodule

/* video_expand.sv */
module video_expand #(
    parameter int color_w = 4
) (
    input  logic                              clk_sys,
    input  logic                              board_rst,
    input  logic                              pxl_cen,
    input  logic [color_w-1:0]                game_r,
    input  logic [color_w-1:0]                game_g,
    input  logic [color_w-1:0]                game_b,
    input  logic                              lhbl,
    input  logic                              lvbl,
    input  logic                              hs,
    input  logic                              vs,
    output logic [board_pkg::out_color_w-1:0] video_r,
    output logic [board_pkg::out_color_w-1:0] video_g,
    output logic [board_pkg::out_color_w-1:0] video_b,
    output logic                              video_hs,
    output logic                              video_vs,
    output logic                              video_de
);

    localparam int ow = board_pkg::out_color_w;

    logic de_in;

    // Repeat the colour bits from the top until the channel is full
    function automatic logic [ow-1:0] widen(input logic [color_w-1:0] c);
        logic [ow-1:0] w;
        for (int i = 0; i < ow; i++)
            w[ow-1-i] = c[color_w-1-(i % color_w)];
        return w;
    endfunction

    assign de_in = lhbl & lvbl;

    always_ff @(posedge clk_sys) begin
        if (board_rst) begin
            video_r  <= '0;
            video_g  <= '0;
            video_b  <= '0;
            video_de <= 1'b0;
        end else if (pxl_cen) begin
            video_de <= de_in;
            video_r  <= de_in ? widen(game_r) : '0;   // Black in blanking
            video_g  <= de_in ? widen(game_g) : '0;
            video_b  <= de_in ? widen(game_b) : '0;
        end
    end

    // Syncs just follow the pixel enable
    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            video_hs <= hs;
            video_vs <= vs;
        end
    end

endmodule

/* board_top.sv */
module board_top #(
    parameter int rst_cnt_w     = 8,
    parameter int three_buttons = 0,
    parameter bit active_low    = 1'b1,
    parameter int color_w       = 4
) (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  logic                              downloading,
    input  logic                              rst_req,
    input  logic                              key_reset,
    input  logic                              key_pause,
    input  logic [board_pkg::gfx_w-1:0]       key_gfx,
    input  logic [board_pkg::joy_w-1:0]       board_joystick1,
    input  logic [board_pkg::joy_w-1:0]       board_joystick2,
    input  logic [board_pkg::game_joy_w-1:0]  key_joy1,
    input  logic [board_pkg::game_joy_w-1:0]  key_joy2,
    input  logic [1:0]                        key_start,
    input  logic [1:0]                        key_coin,
    input  logic                              key_service,
    input  logic [board_pkg::status_w-1:0]    status,
    input  logic                              pxl_cen,
    input  logic [color_w-1:0]                game_r,
    input  logic [color_w-1:0]                game_g,
    input  logic [color_w-1:0]                game_b,
    input  logic                              lhbl,
    input  logic                              lvbl,
    input  logic                              hs,
    input  logic                              vs,
    output logic                              board_rst,
    output logic                              board_rst_n,
    output logic                              game_rst,
    output logic                              game_rst_n,
    output logic                              game_pause,
    output logic [board_pkg::gfx_w-1:0]       gfx_en,
    output logic [board_pkg::game_joy_w-1:0]  game_joystick1,
    output logic [board_pkg::game_joy_w-1:0]  game_joystick2,
    output logic [1:0]                        game_coin,
    output logic [1:0]                        game_start,
    output logic                              game_service,
    output logic                              dip_test,
    output logic                              dip_flip,
    output logic                              dip_pause,
    output logic [1:0]                        dip_fxlevel,
    output logic [board_pkg::out_color_w-1:0] video_r,
    output logic [board_pkg::out_color_w-1:0] video_g,
    output logic [board_pkg::out_color_w-1:0] video_b,
    output logic                              video_hs,
    output logic                              video_vs,
    output logic                              video_de
);

    logic rot_control;
    logic joy_pause;    // Raw pause request from the sticks

    board_ctrl #(.rst_cnt_w(rst_cnt_w)) u_ctrl (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .dip_flip    ( dip_flip    ),
        .key_reset   ( key_reset   ),
        .key_pause   ( key_pause   ),
        .joy_pause   ( joy_pause   ),
        .key_gfx     ( key_gfx     ),
        .board_rst   ( board_rst   ),
        .board_rst_n ( board_rst_n ),
        .game_rst    ( game_rst    ),
        .game_rst_n  ( game_rst_n  ),
        .game_pause  ( game_pause  ),
        .gfx_en      ( gfx_en      )
    );

    input_mapper #(
        .three_buttons ( three_buttons ),
        .active_low    ( active_low    )
    ) u_inputs (
        .clk_sys         ( clk_sys         ),
        .board_rst       ( board_rst       ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .key_joy1        ( key_joy1        ),
        .key_joy2        ( key_joy2        ),
        .key_start       ( key_start       ),
        .key_coin        ( key_coin        ),
        .key_service     ( key_service     ),
        .rot_control     ( rot_control     ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_service    ( game_service    ),
        .joy_pause       ( joy_pause       )
    );

    dip_decode u_dip (
        .clk_sys     ( clk_sys     ),
        .status      ( status      ),
        .game_pause  ( game_pause  ),
        .rot_control ( rot_control ),
        .dip_test    ( dip_test    ),
        .dip_flip    ( dip_flip    ),
        .dip_pause   ( dip_pause   ),
        .dip_fxlevel ( dip_fxlevel )
    );

    video_expand #(.color_w(color_w)) u_video (
        .clk_sys   ( clk_sys   ),
        .board_rst ( board_rst ),
        .pxl_cen   ( pxl_cen   ),
        .game_r    ( game_r    ),
        .game_g    ( game_g    ),
        .game_b    ( game_b    ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .video_r   ( video_r   ),
        .video_g   ( video_g   ),
        .video_b   ( video_b   ),
        .video_hs  ( video_hs  ),
        .video_vs  ( video_vs  ),
        .video_de  ( video_de  )
    );

endmodule

/* board_checker.sv */
module board_checker (
    input logic clk_sys,
    input logic rst,
    input logic board_rst,
    input logic board_rst_n,
    input logic game_rst,
    input logic game_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_fail = 0;    // Failed assertions so far

    // The active-low copies must never release early
    game_rst_n_low: assert property (@(posedge clk_sys) game_rst |-> !game_rst_n)
        else begin
            $error("game_rst_n high while game_rst is high");
            n_fail++;
        end

    board_rst_n_low: assert property (@(posedge clk_sys) board_rst |-> !board_rst_n)
        else begin
            $error("board_rst_n high while board_rst is high");
            n_fail++;
        end

    rst_to_game: assert property (@(posedge clk_sys) rst |=> game_rst)
        else begin
            $error("game_rst did not follow rst");
            n_fail++;
        end

endmodule

bind board_top board_checker checker_inst (.*);

/* tb_clock.sv */
module tb_clock #(
    parameter int half_period = 10,
    parameter int rst_cycles  = 2
) (
    output logic clk_sys,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_sys = 1'b0;
        forever #half_period clk_sys = ~clk_sys;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk_sys);
        rst <= 1'b0;    // Released on the edge like other stimulus
    end

endmodule

/* board_tb.sv */
module board_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [15:0] joy1;
        logic [15:0] joy2;
        logic [31:0] status;
        logic        kpause;
        logic [3:0]  kgfx;
        logic [11:0] rgb;
        logic [1:0]  blank;     // {lhbl, lvbl}
        logic        toggle;    // game_pause flips in this row
    } row_t;

    localparam int n_rows = 12;

    // joy1, joy2, status, key_pause, key_gfx, rgb, {lhbl, lvbl}, pause flips
    row_t rows [n_rows] = '{
        '{16'h0000, 16'h0000, 32'h0000_0000, 1'b0, 4'h0, 12'h000, 2'b11, 1'b0},
        '{16'h0001, 16'h0010, 32'h0000_0000, 1'b0, 4'h1, 12'h5a3, 2'b11, 1'b0},
        '{16'h0005, 16'h0000, 32'h0000_0004, 1'b0, 4'h1, 12'hf0c, 2'b10, 1'b0},
        '{16'h000a, 16'h0003, 32'h0000_0004, 1'b0, 4'h0, 12'h123, 2'b01, 1'b0},
        '{16'h0040, 16'h0080, 32'h0000_0000, 1'b1, 4'h4, 12'h9be, 2'b11, 1'b1},
        '{16'h0100, 16'h0000, 32'h0000_0400, 1'b1, 4'h4, 12'h777, 2'b00, 1'b0},
        '{16'h0200, 16'h0000, 32'h0000_2000, 1'b0, 4'h8, 12'h4c2, 2'b11, 1'b1},
        '{16'h0200, 16'h0200, 32'h0000_6000, 1'b0, 4'h0, 12'hffe, 2'b11, 1'b0},
        '{16'h0000, 16'h0200, 32'h0000_0004, 1'b0, 4'h2, 12'h0f0, 2'b11, 1'b0},
        '{16'h0000, 16'h0000, 32'h0000_0000, 1'b1, 4'hf, 12'h31d, 2'b11, 1'b1},
        '{16'h0200, 16'h03c0, 32'h0000_0004, 1'b0, 4'h0, 12'hab9, 2'b11, 1'b1},
        '{16'hffff, 16'h8421, 32'h0000_0000, 1'b1, 4'h0, 12'hc6e, 2'b11, 1'b1}
    };

    logic        clk_sys, rst, downloading, rst_req, key_reset, key_pause, key_service;
    logic [3:0]  key_gfx, game_r, game_g, game_b, gfx_en;
    logic [15:0] board_joystick1, board_joystick2;
    logic [9:0]  key_joy1, key_joy2, game_joystick1, game_joystick2;
    logic [1:0]  key_start, key_coin, game_coin, game_start, dip_fxlevel;
    logic [31:0] status;
    logic        pxl_cen, lhbl, lvbl, hs, vs;
    logic        board_rst, board_rst_n, game_rst, game_rst_n, game_pause, game_service;
    logic        dip_test, dip_flip, dip_pause, video_hs, video_vs, video_de;
    logic [7:0]  video_r, video_g, video_b;

    int          n_errors = 0;
    int          n_checks = 0;
    logic [31:0] lfsr = 32'h3f09036a;
    logic        trig_phase = 1'b0;
    logic        exp_pause;
    logic [3:0]  exp_gfx, prev_gfx;

    tb_clock clock_gen (.clk_sys(clk_sys), .rst(rst));

    board_top #(
        .rst_cnt_w(4), .three_buttons(0), .active_low(1'b1), .color_w(4)
    ) board_top_inst (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];    // One step per bit
        end
    endtask

    // Expected game stick: merge, optional turn, then active low
    function automatic logic [9:0] ref_joy(input logic [15:0] board, input logic [9:0] keys,
                                           input logic rot);
        logic [9:0] m;
        logic [9:0] r;
        m = board[9:0] | keys;
        r = m;
        if (rot) begin
            r[0] = m[2];
            r[1] = m[3];
            r[2] = m[1];
            r[3] = m[0];
        end
        return ~r;
    endfunction

    function automatic logic [7:0] ref_color(input logic [3:0] c, input logic de);
        return de ? {c, c} : 8'h00;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic wait_for(input bit game, input logic level, input int limit,
                            input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk_sys);
            n++;
        end while (((game ? game_rst : board_rst) !== level) && n < limit);
        if ((game ? game_rst : board_rst) !== level) begin
            n_errors++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] v;
        take_bits(27, v);    // Keys and syncs not set by the row
        @(posedge clk_sys);
        board_joystick1 <= r.joy1;
        board_joystick2 <= r.joy2;
        status          <= r.status;
        key_pause       <= r.kpause;
        key_gfx         <= r.kgfx;
        {game_r, game_g, game_b} <= r.rgb;
        {lhbl, lvbl}    <= r.blank;
        key_joy1        <= v[9:0];
        key_joy2        <= v[19:10];
        key_start       <= v[21:20];
        key_coin        <= v[23:22];
        key_service     <= v[24];
        hs              <= v[25];
        vs              <= v[26];
    endtask

    task automatic check_row(input row_t r);
        logic       rot;
        logic       de;
        logic [1:0] e_coin;
        logic [1:0] e_start;
        logic       e_service;
        logic       e_dpause;
        rot       = r.status[board_pkg::st_rotate];
        de        = r.blank[1] & r.blank[0];
        e_coin[0] = ~(r.joy1[board_pkg::coin_base] | key_coin[0]);
        e_coin[1] = ~(r.joy2[board_pkg::coin_base] | key_coin[1]);
        e_start   = ~({r.joy1[board_pkg::start2_base] | r.joy2[board_pkg::start2_base],
                       r.joy1[board_pkg::start1_base] | r.joy2[board_pkg::start1_base]}
                      | key_start);
        e_service = ~key_service;
        e_dpause  = ~(exp_pause | r.status[board_pkg::st_pause]);
        check(game_joystick1, ref_joy(r.joy1, key_joy1, rot), "game_joystick1");
        check(game_joystick2, ref_joy(r.joy2, key_joy2, rot), "game_joystick2");
        check(game_coin, e_coin, "game_coin");
        check(game_start, e_start, "game_start");
        check(game_service, e_service, "game_service");
        check(game_pause, exp_pause, "game_pause");
        check(dip_pause, e_dpause, "dip_pause");
        check(gfx_en, exp_gfx, "gfx_en");
        check(dip_test, r.status[board_pkg::st_test], "dip_test");
        check(dip_flip, r.status[board_pkg::st_flip], "dip_flip");
        check(dip_fxlevel, r.status[board_pkg::st_fx_lo +: 2], "dip_fxlevel");
        check(video_de, de, "video_de");
        check(video_r, ref_color(r.rgb[11:8], de), "video_r");
        check(video_g, ref_color(r.rgb[7:4], de), "video_g");
        check(video_b, ref_color(r.rgb[3:0], de), "video_b");
        check(video_hs, hs, "video_hs");
        check(video_vs, vs, "video_vs");
    endtask

    task automatic trigger_game_reset(input int kind, input string what);
        @(posedge clk_sys);
        case (kind)
            0:       status <= status ^ (32'd1 << board_pkg::st_flip);
            1:       rst_req <= 1'b1;
            default: key_reset <= 1'b1;
        endcase
        @(posedge clk_sys);
        rst_req   <= 1'b0;
        key_reset <= 1'b0;
        wait_for(1'b1, 1'b1, 5, {"game_rst after ", what});
        wait_for(1'b1, 1'b0, 20, {"game_rst release after ", what});
        repeat (2) @(negedge clk_sys);
        check(game_rst_n, 1'b1, {"game_rst_n after ", what});
        check(dip_flip, status[board_pkg::st_flip], {"dip_flip after ", what});
    endtask

    // Game reset triggers must leave the board reset alone
    always @(negedge clk_sys)
        if (trig_phase)
            check(board_rst, 1'b0, "board_rst during game reset");

    initial begin
        downloading = 1'b0;
        rst_req = 1'b0;
        key_reset = 1'b0;
        key_pause = 1'b0;
        key_gfx = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        key_joy1 = '0;
        key_joy2 = '0;
        key_start = '0;
        key_coin = '0;
        key_service = 1'b0;
        status = '0;
        pxl_cen = 1'b1;
        {game_r, game_g, game_b} = '0;
        {lhbl, lvbl, hs, vs} = '0;
        exp_pause = 1'b0;
        exp_gfx = '1;
        prev_gfx = '0;

        wait_for(1'b0, 1'b0, 20, "board_rst release");
        wait_for(1'b1, 1'b0, 20, "game_rst release");
        check(gfx_en, 4'hf, "gfx_en after reset");
        check(game_pause, 1'b0, "game_pause after reset");
        check(board_rst_n, 1'b1, "board_rst_n after reset");
        check(game_joystick1, 10'h3ff, "game_joystick1 after reset");
        check(game_joystick2, 10'h3ff, "game_joystick2 after reset");
        check({game_coin, game_start, game_service}, 5'h1f, "coin/start/service after reset");

        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
            repeat (3) @(posedge clk_sys);
            @(negedge clk_sys);
            exp_pause = exp_pause ^ rows[i].toggle;
            for (int b = 0; b < 4; b++) begin
                if (rows[i].kgfx[b] && !prev_gfx[b])
                    exp_gfx[b] = ~exp_gfx[b];    // Pressed key flips its layer
            end
            prev_gfx  = rows[i].kgfx;
            check_row(rows[i]);
        end

        trig_phase = 1'b1;
        trigger_game_reset(0, "flip change");
        trigger_game_reset(1, "rst_req");
        trigger_game_reset(2, "key_reset");
        trig_phase = 1'b0;

        n_errors += board_top_inst.checker_inst.n_fail;
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        repeat (n_rows * 10 + 200) @(posedge clk_sys);
        $display("Watchdog expired before the tests finished");
        $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("Errors found");
        $finish;
    end

endmodule

/* list.f */
board_pkg.sv
board_ctrl.sv
input_mapper.sv
dip_decode.sv
video_expand.sv
board_top.sv
board_checker.sv
tb_clock.sv
board_tb.sv
